// File: hdl/mm_pkg.sv
package mm_pkg;

  // Element and accumulator widths
  localparam int unsigned DATA_W = 16; // Signed X and W elements
  localparam int unsigned ACC_W  = 32; // Sums, bias, results, wrap mod 2^ACC_W

  // Dot product sign applied in the accumulate stage
  typedef enum logic {
    OP_MADD = 1'b0, // Running value plus dot
    OP_MSUB = 1'b1  // Running value minus dot
  } op_e;

  // Sequencing FSM states
  typedef enum logic [1:0] {
    IDLE   = 2'd0, // Nothing in flight, X may load
    STREAM = 2'd1, // Beat taken last cycle
    DRAIN  = 2'd2  // Waiting for pipeline to empty
  } ctrl_state_e;

  // Control fields that ride along with each weight beat
  typedef struct packed {
    logic valid; // Beat present
    logic first; // Start from bias
    logic last;  // Publish result
    op_e  op;    // Add or subtract
  } beat_t;

endpackage

// File: hdl/mm_x_buffer.sv
`timescale 1ns/100ps

module mm_x_buffer #(
  parameter int unsigned HEIGHT = 4,
  parameter int unsigned WIDTH  = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                                         load_en_i, // From controller
  input  logic                                         x_load_i,  // One row per strobe
  input  logic [HEIGHT-1:0][mm_pkg::DATA_W-1:0]        x_row_i,
  output logic [WIDTH-1:0][HEIGHT-1:0][mm_pkg::DATA_W-1:0] x_tile_o
);
  import mm_pkg::*;

  // Pointer needs at least one bit even for a single row
  localparam int unsigned PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

  logic [PTR_W-1:0]                     ptr_q;
  logic [WIDTH-1:0][HEIGHT-1:0][DATA_W-1:0] tile_q;
  logic                                 wr_en;

  assign wr_en = load_en_i & x_load_i; // Strobes outside IDLE dropped

  // Row pointer, wraps after the last row
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (wr_en) begin
      if (ptr_q == PTR_W'(WIDTH - 1))
        ptr_q <= '0;
      else
        ptr_q <= ptr_q + 1'b1;
    end
  end

  // Tile storage
  always_ff @(posedge clk_i) begin
    if (wr_en)
      tile_q[ptr_q] <= x_row_i;
  end

  assign x_tile_o = tile_q; // Static during a stream

endmodule

// File: hdl/mm_mac_stage.sv
`timescale 1ns/100ps

module mm_mac_stage (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        en_i,   // Row clock enable
  input  logic [mm_pkg::DATA_W-1:0]   x_i,    // Operand element
  input  logic [mm_pkg::DATA_W-1:0]   w_i,    // Skewed weight element
  input  logic [mm_pkg::ACC_W-1:0]    psum_i, // From previous stage
  input  mm_pkg::beat_t               beat_i,
  output logic [mm_pkg::ACC_W-1:0]    psum_o,
  output mm_pkg::beat_t               beat_o
);
  import mm_pkg::*;

  logic signed [ACC_W-1:0] prod; // Sign extended product
  logic [ACC_W-1:0]        psum_q;
  beat_t                   beat_q;

  // Both operands signed so they extend to ACC_W before multiply
  assign prod = $signed(x_i) * $signed(w_i);

  // Beat control, valid must come up clean
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_q <= '0;
    end else if (en_i) begin
      beat_q <= beat_i;
    end
  end

  // Partial sum, wraps modulo 2^ACC_W
  always_ff @(posedge clk_i) begin
    if (en_i)
      psum_q <= psum_i + prod;
  end

  assign psum_o = psum_q;
  assign beat_o = beat_q;

endmodule

// File: hdl/mm_row.sv
`timescale 1ns/100ps

module mm_row #(
  parameter int unsigned HEIGHT = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  en_i,
  input  logic [HEIGHT-1:0][mm_pkg::DATA_W-1:0] x_row_i, // Static operand row
  input  logic [HEIGHT-1:0][mm_pkg::DATA_W-1:0] w_vec_i, // Shared weight vector
  input  mm_pkg::beat_t                         beat_i,
  output logic [mm_pkg::ACC_W-1:0]              dot_o,   // Dot product, H cycles later
  output mm_pkg::beat_t                         beat_o
);
  import mm_pkg::*;

  logic [HEIGHT:0][ACC_W-1:0]    psum;   // Stage k reads psum[k]
  beat_t [HEIGHT:0]              beat_c; // Beat chain
  logic [HEIGHT-1:0][DATA_W-1:0] w_skew; // Weight k delayed by k cycles

  assign psum[0]   = '0; // Chain starts from zero
  assign beat_c[0] = beat_i;

  for (genvar k = 0; k < HEIGHT; k++) begin : g_stage
    if (k == 0) begin : g_no_skew
      assign w_skew[k] = w_vec_i[k]; // First stage needs no delay
    end else begin : g_skew
      logic [k-1:0][DATA_W-1:0] sr_q; // k deep shift register

      always_ff @(posedge clk_i) begin
        if (en_i) begin
          sr_q[0] <= w_vec_i[k];
          for (int j = 1; j < k; j++)
            sr_q[j] <= sr_q[j-1];
        end
      end

      assign w_skew[k] = sr_q[k-1];
    end

    mm_mac_stage u_mac (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .en_i   (en_i),
      .x_i    (x_row_i[k]),
      .w_i    (w_skew[k]),
      .psum_i (psum[k]),
      .beat_i (beat_c[k]),
      .psum_o (psum[k+1]),
      .beat_o (beat_c[k+1])
    );
  end

  assign dot_o  = psum[HEIGHT];
  assign beat_o = beat_c[HEIGHT];

endmodule

// File: hdl/mm_accum.sv
`timescale 1ns/100ps

module mm_accum #(
  parameter int unsigned HEIGHT = 4,
  parameter int unsigned WIDTH  = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [WIDTH-1:0][mm_pkg::ACC_W-1:0] dot_i,  // One per row
  input  mm_pkg::beat_t                       beat_i, // Row 0 beat, shared timing
  input  logic [WIDTH-1:0][mm_pkg::ACC_W-1:0] bias_i, // Raw input bias
  output logic [WIDTH-1:0][mm_pkg::ACC_W-1:0] z_o,
  output logic                                z_valid_o
);
  import mm_pkg::*;

  logic [HEIGHT-1:0][WIDTH-1:0][ACC_W-1:0] bias_pipe_q; // Matches row latency
  logic [WIDTH-1:0][ACC_W-1:0]             bias_d;
  logic [WIDTH-1:0][ACC_W-1:0]             run_q;       // Running value per row
  logic [WIDTH-1:0][ACC_W-1:0]             run_nxt;
  logic [WIDTH-1:0][ACC_W-1:0]             z_q;
  logic                                    z_valid_q;

  // Bias delay, free running since only first beats use the tap
  always_ff @(posedge clk_i) begin
    bias_pipe_q[0] <= bias_i;
    for (int k = 1; k < HEIGHT; k++)
      bias_pipe_q[k] <= bias_pipe_q[k-1];
  end

  assign bias_d = bias_pipe_q[HEIGHT-1];

  // Feedback mux then add or subtract
  always_comb begin
    logic [ACC_W-1:0] base;
    for (int r = 0; r < WIDTH; r++) begin
      base = beat_i.first ? bias_d[r] : run_q[r]; // Bias on first beat
      if (beat_i.op == OP_MSUB)
        run_nxt[r] = base - dot_i[r];
      else
        run_nxt[r] = base + dot_i[r];
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_i.valid)
      run_q <= run_nxt;
    if (beat_i.valid && beat_i.last)
      z_q <= run_nxt; // Held until next publish
  end

  // One cycle publish strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      z_valid_q <= 1'b0;
    end else begin
      z_valid_q <= beat_i.valid & beat_i.last;
    end
  end

  assign z_o       = z_q;
  assign z_valid_o = z_valid_q;

endmodule

// File: hdl/mm_ctrl.sv
`timescale 1ns/100ps

module mm_ctrl #(
  parameter int unsigned HEIGHT = 4,
  parameter int unsigned WIDTH  = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             w_valid_i,   // New beat entering rows
  input  logic             done_i,      // Beat reaching accumulate stage
  output logic             x_load_en_o,
  output logic [WIDTH-1:0] row_en_o,
  output logic             busy_o
);
  import mm_pkg::*;

  // Up to HEIGHT+1 beats in flight
  localparam int unsigned CNT_W = $clog2(HEIGHT + 2);

  ctrl_state_e      state_q;
  ctrl_state_e      state_nxt;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_nxt;
  logic             active;

  // In-flight bookkeeping
  assign cnt_nxt = cnt_q + CNT_W'(w_valid_i) - CNT_W'(done_i);

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      IDLE: begin
        if (w_valid_i)
          state_nxt = STREAM;
      end
      STREAM: begin
        if (!w_valid_i)
          state_nxt = (cnt_nxt == '0) ? IDLE : DRAIN; // Short pipes may empty at once
      end
      DRAIN: begin
        if (w_valid_i)
          state_nxt = STREAM; // Stream resumes
        else if (cnt_nxt == '0)
          state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_nxt;
      cnt_q   <= cnt_nxt;
    end
  end

  // Rows advance on the incoming beat and while anything is inside
  assign active   = w_valid_i | (cnt_q != '0);
  assign row_en_o = {WIDTH{active}};
  assign busy_o   = (cnt_q != '0);

  // No X write on the edge that takes a first beat
  assign x_load_en_o = (state_q == IDLE) & ~w_valid_i;

endmodule

// File: hdl/mm_top.sv
`timescale 1ns/100ps

module mm_top #(
  parameter int unsigned HEIGHT = 4, // MAC stages per row
  parameter int unsigned WIDTH  = 4  // Parallel rows
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Operand load
  input  logic                                  x_load_i,
  input  logic [HEIGHT-1:0][mm_pkg::DATA_W-1:0] x_row_i,
  // Weight beats
  input  logic                                  w_valid_i,
  input  logic [HEIGHT-1:0][mm_pkg::DATA_W-1:0] w_vec_i,
  input  logic [WIDTH-1:0][mm_pkg::ACC_W-1:0]   y_bias_i,  // Used on first beats
  input  logic                                  first_i,
  input  logic                                  last_i,
  input  mm_pkg::op_e                           op_i,
  // Results
  output logic                                  z_valid_o,
  output logic [WIDTH-1:0][mm_pkg::ACC_W-1:0]   z_o,
  output logic                                  busy_o
);
  import mm_pkg::*;

  logic [WIDTH-1:0][HEIGHT-1:0][DATA_W-1:0] x_tile;
  logic                                     x_load_en;
  logic [WIDTH-1:0]                         row_en;
  logic [WIDTH-1:0][ACC_W-1:0]              row_dot;
  beat_t [WIDTH-1:0]                        row_beat;
  beat_t                                    beat_in;

  // Beat struct packing
  assign beat_in = '{valid: w_valid_i, first: first_i, last: last_i, op: op_i};

  mm_x_buffer #(.HEIGHT(HEIGHT), .WIDTH(WIDTH)) u_xbuf (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .load_en_i (x_load_en),
    .x_load_i  (x_load_i),
    .x_row_i   (x_row_i),
    .x_tile_o  (x_tile)
  );

  // Array of rows, all see the same weights
  for (genvar r = 0; r < WIDTH; r++) begin : g_row
    mm_row #(.HEIGHT(HEIGHT)) u_row (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .en_i    (row_en[r]),
      .x_row_i (x_tile[r]),
      .w_vec_i (w_vec_i),
      .beat_i  (beat_in),
      .dot_o   (row_dot[r]),
      .beat_o  (row_beat[r])
    );
  end

  mm_accum #(.HEIGHT(HEIGHT), .WIDTH(WIDTH)) u_accum (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .dot_i     (row_dot),
    .beat_i    (row_beat[0]), // Row 0 stands for all
    .bias_i    (y_bias_i),
    .z_o       (z_o),
    .z_valid_o (z_valid_o)
  );

  mm_ctrl #(.HEIGHT(HEIGHT), .WIDTH(WIDTH)) u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .w_valid_i   (w_valid_i),
    .done_i      (row_beat[0].valid),
    .x_load_en_o (x_load_en),
    .row_en_o    (row_en),
    .busy_o      (busy_o)
  );

endmodule

// File: sim/mm_tb_assert.sv
`timescale 1ns/100ps

module mm_tb_assert (
  input logic clk_i,
  input logic rst_i,
  input logic idle_i,      // Controller in IDLE
  input logic busy_i,
  input logic x_load_en_i,
  input logic cnt_zero_i,  // Nothing in flight
  input logic done_i,      // Beat leaving the rows
  input logic in_flight_i, // Controller still counts a beat
  input logic z_valid_i
);

  // Count only drops with a beat inside
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    !(cnt_zero_i && done_i))
    else $error("in-flight count underflow");

  a_idle_not_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    idle_i |-> !busy_i)
    else $error("busy_o high in IDLE");

  // Publish path against the controller's own bookkeeping
  a_pulse_has_beat: assert property (@(posedge clk_i) disable iff (rst_i)
    z_valid_i |-> $past(in_flight_i))
    else $error("z_valid_o pulse with no beat in flight");

  a_load_gated: assert property (@(posedge clk_i) disable iff (rst_i)
    busy_i |-> !x_load_en_i)
    else $error("X load enabled while busy");

endmodule

bind mm_ctrl mm_tb_assert u_ctrl_chk (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .idle_i      (state_q == mm_pkg::IDLE),
  .busy_i      (busy_o),
  .x_load_en_i (x_load_en_o),
  .cnt_zero_i  (cnt_q == '0),
  .done_i      (done_i),
  .in_flight_i (1'b1),
  .z_valid_i   (1'b0)
);

bind mm_top mm_tb_assert u_top_chk (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .idle_i      (1'b0),
  .busy_i      (1'b0),
  .x_load_en_i (1'b0),
  .cnt_zero_i  (1'b1),
  .done_i      (1'b0),
  .in_flight_i (busy_o),   // High while the counter is nonzero
  .z_valid_i   (z_valid_o)
);

// File: sim/mm_tb.sv
`timescale 1ns/100ps

module mm_tb;
  import mm_pkg::*;

  localparam int unsigned H       = 4;
  localparam int unsigned W       = 4;
  localparam int          TIMEOUT = 200; // Cycles allowed for any single wait

  logic                     clk_i;
  logic                     rst_i;
  logic                     x_load_i;
  logic [H-1:0][DATA_W-1:0] x_row_i;
  logic                     w_valid_i;
  logic [H-1:0][DATA_W-1:0] w_vec_i;
  logic [W-1:0][ACC_W-1:0]  y_bias_i;
  logic                     first_i;
  logic                     last_i;
  op_e                      op_i;
  logic                     z_valid_o;
  logic [W-1:0][ACC_W-1:0]  z_o;
  logic                     busy_o;

  // Reference model state
  logic [W-1:0][H-1:0][DATA_W-1:0] x_mdl;   // Tile as the model sees it
  logic [W-1:0][ACC_W-1:0]         run_mdl; // Running value per row
  int                              ptr_mdl;
  logic [W-1:0][ACC_W-1:0]         exp_z_q[$];
  int                              exp_cyc_q[$]; // Cycle each pulse is due
  int                              cyc = 0;
  integer                          seed;
  int                              sent = 0;     // Last beats sent
  int                              pulses = 0;   // Pulses seen
  int                              z_err = 0;
  int                              flag_err = 0;
  int                              other_err = 0;
  int                              mon_err = 0;

  mm_top #(.HEIGHT(H), .WIDTH(W)) DUT (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .x_load_i  (x_load_i),
    .x_row_i   (x_row_i),
    .w_valid_i (w_valid_i),
    .w_vec_i   (w_vec_i),
    .y_bias_i  (y_bias_i),
    .first_i   (first_i),
    .last_i    (last_i),
    .op_i      (op_i),
    .z_valid_o (z_valid_o),
    .z_o       (z_o),
    .busy_o    (busy_o)
  );

  always #4 clk_i = ~clk_i; // 8 ns period

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic check_z(input int row, input logic [ACC_W-1:0] got,
                         input logic [ACC_W-1:0] exp);
    if (got !== exp) begin
      z_err++;
      $display("error: z_o[%0d] got %h expected %h", row, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_err++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r[15:0]) % (hi - lo + 1);
  endfunction

  // Random element, corner values in extreme mode
  function automatic logic [DATA_W-1:0] rand_elem(input bit extreme);
    logic [31:0] r;
    r = $random(seed);
    if (!extreme)
      return r[DATA_W-1:0];
    case (r[1:0])
      2'd0:    return 16'h8000; // Most negative
      2'd1:    return 16'h7fff;
      2'd2:    return 16'hffff;
      default: return 16'h8001;
    endcase
  endfunction

  function automatic logic [ACC_W-1:0] rand_bias(input bit extreme);
    logic [31:0] r;
    r = $random(seed);
    if (!extreme || r[1:0] == 2'd3)
      return r;
    case (r[1:0])
      2'd0:    return 32'h7fffffff;
      2'd1:    return 32'h80000000;
      default: return 32'hffffffff;
    endcase
  endfunction

  // Signed dot product of one model row, wraps mod 2^32
  function automatic logic [ACC_W-1:0] dot_mdl(input int r,
                                               input logic [H-1:0][DATA_W-1:0] w);
    logic signed [ACC_W-1:0] xs;
    logic signed [ACC_W-1:0] ws;
    logic [ACC_W-1:0]        acc;
    acc = '0;
    for (int k = 0; k < H; k++) begin
      xs  = {{(ACC_W-DATA_W){x_mdl[r][k][DATA_W-1]}}, x_mdl[r][k]};
      ws  = {{(ACC_W-DATA_W){w[k][DATA_W-1]}}, w[k]};
      acc = acc + xs * ws;
    end
    return acc;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #1; // Drive just after the edge
  endtask

  task automatic gap(input int n);
    repeat (n) step();
  endtask

  // One X row, taken only when the engine is idle
  task automatic load_row(input bit extreme, input bit taken_exp);
    logic [H-1:0][DATA_W-1:0] row;
    for (int k = 0; k < H; k++)
      row[k] = rand_elem(extreme);
    x_load_i = 1'b1;
    x_row_i  = row;
    check_flag("busy_o", busy_o, !taken_exp);
    if (taken_exp) begin
      x_mdl[ptr_mdl] = row;
      ptr_mdl        = (ptr_mdl + 1) % W; // Pointer wraps after last row
    end
    step();
    x_load_i = 1'b0;
  endtask

  task automatic send_beat(input bit first, input bit last, input bit extreme);
    logic [H-1:0][DATA_W-1:0] w;
    logic [W-1:0][ACC_W-1:0]  b;
    logic [ACC_W-1:0]         dot;
    logic [ACC_W-1:0]         base;
    op_e                      op;
    for (int k = 0; k < H; k++)
      w[k] = rand_elem(extreme);
    for (int r = 0; r < W; r++)
      b[r] = rand_bias(extreme);
    op        = (rand_range(0, 1) == 1) ? OP_MSUB : OP_MADD;
    w_valid_i = 1'b1;
    w_vec_i   = w;
    y_bias_i  = b;
    first_i   = first;
    last_i    = last;
    op_i      = op;
    for (int r = 0; r < W; r++) begin
      dot        = dot_mdl(r, w);
      base       = first ? b[r] : run_mdl[r]; // Bias only on first beat
      run_mdl[r] = (op == OP_MSUB) ? base - dot : base + dot;
    end
    if (last) begin
      exp_z_q.push_back(run_mdl);
      exp_cyc_q.push_back(cyc + H + 1); // H+1 cycles to the pulse
      sent++;
    end
    step();
    w_valid_i = 1'b0;
    first_i   = 1'b0;
    last_i    = 1'b0;
    check_flag("busy_o", busy_o, 1'b1);
  endtask

  // Sequence of n beats, optional random gaps
  task automatic run_seq(input int n, input int max_gap, input bit extreme);
    for (int i = 0; i < n; i++) begin
      send_beat(i == 0, i == n - 1, extreme);
      if (max_gap > 0)
        gap(rand_range(0, max_gap));
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((busy_o || exp_z_q.size() != 0) && n < TIMEOUT) begin
      step();
      n++;
    end
    if (n >= TIMEOUT) begin
      other_err++;
      $display("timeout: engine still busy or results missing after %0d cycles", TIMEOUT);
    end
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("z_valid_o", z_valid_o, 1'b0);
  endtask

  task automatic load_tile(input bit extreme);
    wait_idle();
    repeat (W) load_row(extreme, 1'b1);
  endtask

  // Result monitor, samples on the falling edge
  always @(negedge clk_i) begin : monitor
    logic [W-1:0][ACC_W-1:0] exp;
    int                      ecyc;
    if (!rst_i && z_valid_o) begin
      if (exp_z_q.size() == 0) begin
        mon_err++;
        $display("z_valid_o pulsed while no result was expected");
      end else begin
        exp  = exp_z_q.pop_front();
        ecyc = exp_cyc_q.pop_front();
        for (int r = 0; r < W; r++)
          check_z(r, z_o[r], exp[r]);
        if (cyc != ecyc) begin
          mon_err++;
          $display("z_valid_o came at cycle %0d instead of cycle %0d", cyc, ecyc);
        end
        pulses++;
      end
    end
  end

  initial begin : main
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    x_load_i  = 1'b0;
    x_row_i   = '0;
    w_valid_i = 1'b0;
    w_vec_i   = '0;
    y_bias_i  = '0;
    first_i   = 1'b0;
    last_i    = 1'b0;
    op_i      = OP_MADD;
    seed      = 32'he8f4;
    ptr_mdl   = 0;
    run_mdl   = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Quiet until the first beat
    repeat (4) begin
      check_flag("z_valid_o", z_valid_o, 1'b0);
      check_flag("busy_o", busy_o, 1'b0);
      step();
    end
    load_tile(1'b0);

    repeat (4) send_beat(1'b1, 1'b1, 1'b0); // Single-beat sequences
    wait_idle();

    repeat (12) run_seq(rand_range(2, 6), 0, 1'b0); // Back to back
    wait_idle();

    load_tile(1'b1); // Corner operands for the wrap
    repeat (8) run_seq(rand_range(2, 6), 0, 1'b1);
    wait_idle();

    // Loads while busy must be dropped
    load_tile(1'b0);
    run_seq(3, 0, 1'b0);
    load_row(1'b0, 1'b0);
    load_row(1'b0, 1'b0);
    run_seq(3, 0, 1'b0); // Still the old tile
    load_tile(1'b0);     // Reload in IDLE
    run_seq(4, 0, 1'b0);
    wait_idle();

    repeat (10) run_seq(rand_range(2, 6), H + 3, 1'b0); // Gaps, busy toggles
    wait_idle();
    gap(4);

    if (pulses != sent) begin
      other_err++;
      $display("saw %0d result pulses for %0d sequences", pulses, sent);
    end
    $display("errors: z_o %0d, flags %0d, other %0d", z_err, flag_err, other_err + mon_err);
    if (z_err + flag_err + other_err + mon_err == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sim.f
hdl/mm_pkg.sv
hdl/mm_x_buffer.sv
hdl/mm_mac_stage.sv
hdl/mm_row.sv
hdl/mm_accum.sv
hdl/mm_ctrl.sv
hdl/mm_top.sv
sim/mm_tb_assert.sv
sim/mm_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the mm_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module mm_tb \
  -Mdir "$BUILD_DIR" -o mm_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/mm_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
